// ==== fetch_defs_pkg.sv ====
package fetch_defs_pkg;

  // ------------------------------------------------------------------
  // widths and layout of the fetch datapath
  // ------------------------------------------------------------------
  localparam int XLEN           = 32;
  // byte step between two sequential instruction words
  localparam int INSTR_BYTES    = 4;
  localparam int TRAP_BASE_W    = 24;
  localparam int VEC_ID_W       = 5;
  // zero bits below the trap base for a plain exception
  localparam int EXC_OFF_W      = XLEN - TRAP_BASE_W;
  // vectored entries are one word apart
  localparam int IRQ_PAD_W      = 2;
  localparam int PREFETCH_DEPTH = 2;

  // ------------------------------------------------------------------
  // selector encodings driven by the core controller
  // ------------------------------------------------------------------
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_FENCEI    = 3'b001,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_MRET      = 3'b101,
    PC_DRET      = 3'b111
  } pc_mux_e;

  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'b00,
    EXC_PC_IRQ       = 2'b01,
    EXC_PC_DBD       = 2'b10
  } exc_pc_mux_e;

  typedef enum logic [1:0] {
    TRAP_MACHINE  = 2'b00,
    TRAP_USER     = 2'b01,
    TRAP_MACHINEX = 2'b10
  } trap_mux_e;

  // offset fsm, aligned fetch only
  typedef enum logic [0:0] {
    IDLE = 1'b0,
    WAIT = 1'b1
  } offset_state_e;

endpackage

// ==== fetch_csr_pkg.sv ====
package fetch_csr_pkg;

  // ------------------------------------------------------------------
  // apb bus geometry
  // ------------------------------------------------------------------
  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  typedef logic [APB_ADDR_W-1:0] apb_addr_t;

  // register offsets, one word apart
  localparam apb_addr_t CSR_BOOT   = 8'h00;
  localparam apb_addr_t CSR_MTVEC  = 8'h04;
  localparam apb_addr_t CSR_UTVEC  = 8'h08;
  localparam apb_addr_t CSR_MTVECX = 8'h0C;
  localparam apb_addr_t CSR_HALT   = 8'h10;
  localparam apb_addr_t CSR_CTRL   = 8'h14;

  // reset values
  localparam logic [APB_DATA_W-1:0] BOOT_RESET = 32'h0000_0080;
  localparam logic [APB_DATA_W-1:0] HALT_RESET = 32'h1A11_0800;
  localparam logic [APB_DATA_W-1:0] TVEC_RESET = 32'h0000_0000;

endpackage

// ==== fetch_stream_if.sv ====
`timescale 1ns/1ps

// word stream from the prefetch buffer into the fetch stage
interface fetch_stream_if;
  // redirect, also flushes the buffer
  logic        branch;
  logic [31:0] branch_addr;
  // head of the prefetch fifo
  logic        valid;
  logic [31:0] rdata;
  logic        failed;
  // fetch stage takes the head word
  logic        ready;

  modport fetch (
    output branch, branch_addr, ready,
    input  valid, rdata, failed
  );

  modport buffer (
    input  branch, branch_addr, ready,
    output valid, rdata, failed
  );

endinterface

// ==== fetch_csr_apb.sv ====
`timescale 1ns/1ps

module fetch_csr_apb
  import fetch_defs_pkg::*, fetch_csr_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  // apb slave
  input  apb_addr_t              paddr_i,
  input  logic [APB_DATA_W-1:0]  pwdata_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  output logic [APB_DATA_W-1:0]  prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  // configuration towards the fetch logic
  output logic [XLEN-1:0]        boot_addr_o,
  output logic [TRAP_BASE_W-1:0] m_trap_base_o,
  output logic [TRAP_BASE_W-1:0] u_trap_base_o,
  output logic [TRAP_BASE_W-1:0] mx_trap_base_o,
  output logic [XLEN-1:0]        halt_addr_o,
  output logic                   fetch_en_o
);

  logic [APB_DATA_W-1:0] boot_q;
  logic [APB_DATA_W-1:0] mtvec_q;
  logic [APB_DATA_W-1:0] utvec_q;
  logic [APB_DATA_W-1:0] mtvecx_q;
  logic [APB_DATA_W-1:0] halt_q;
  logic                  en_q;
  logic                  access;
  logic                  addr_hit;

  // ------------------------------------------------------------------
  // address decode and read mux
  // ------------------------------------------------------------------
  assign access = psel_i & penable_i;

  always_comb begin
    addr_hit = 1'b1;
    prdata_o = '0;
    case (paddr_i)
      CSR_BOOT:   prdata_o = boot_q;
      CSR_MTVEC:  prdata_o = mtvec_q;
      CSR_UTVEC:  prdata_o = utvec_q;
      CSR_MTVECX: prdata_o = mtvecx_q;
      CSR_HALT:   prdata_o = halt_q;
      // only the enable bit is implemented
      CSR_CTRL:   prdata_o = {{(APB_DATA_W-1){1'b0}}, en_q};
      default:    addr_hit = 1'b0;
    endcase
  end

  // zero wait states
  assign pready_o  = 1'b1;
  assign pslverr_o = access & ~addr_hit;

  // ------------------------------------------------------------------
  // register write, visible the cycle after the access phase
  // ------------------------------------------------------------------
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      boot_q   <= BOOT_RESET;
      mtvec_q  <= TVEC_RESET;
      utvec_q  <= TVEC_RESET;
      mtvecx_q <= TVEC_RESET;
      halt_q   <= HALT_RESET;
      en_q     <= 1'b0;
    end else if (access && pwrite_i && addr_hit) begin
      case (paddr_i)
        // boot address is halfword aligned at least
        CSR_BOOT:   boot_q   <= {pwdata_i[APB_DATA_W-1:1], 1'b0};
        CSR_MTVEC:  mtvec_q  <= pwdata_i;
        CSR_UTVEC:  utvec_q  <= pwdata_i;
        CSR_MTVECX: mtvecx_q <= pwdata_i;
        CSR_HALT:   halt_q   <= pwdata_i;
        CSR_CTRL:   en_q     <= pwdata_i[0];
        default: ;
      endcase
    end
  end

  // trap bases are the upper bits of each tvec register
  assign boot_addr_o    = boot_q;
  assign m_trap_base_o  = mtvec_q[XLEN-1 -: TRAP_BASE_W];
  assign u_trap_base_o  = utvec_q[XLEN-1 -: TRAP_BASE_W];
  assign mx_trap_base_o = mtvecx_q[XLEN-1 -: TRAP_BASE_W];
  assign halt_addr_o    = halt_q;
  assign fetch_en_o     = en_q;

endmodule

// ==== prefetch_buffer.sv ====
`timescale 1ns/1ps

module prefetch_buffer
  import fetch_defs_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            fetch_en_i,
  fetch_stream_if.buffer  stream,
  // instruction memory
  output logic            instr_req_o,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  logic [XLEN-1:0] instr_rdata_i,
  input  logic            instr_err_i,
  output logic            busy_o
);

  localparam int                CNT_W   = $clog2(PREFETCH_DEPTH + 1);
  localparam logic [CNT_W:0]    DEPTH_C = (CNT_W+1)'(PREFETCH_DEPTH);

  logic [XLEN-1:0]  addr_q;
  logic [XLEN-1:0]  pend_addr_q;
  logic             wait_q;
  logic             stale_q;
  logic [CNT_W-1:0] out_cnt_q;
  logic [CNT_W-1:0] out_cnt_d;
  logic [CNT_W-1:0] disc_cnt_q;
  logic [CNT_W-1:0] fifo_cnt_q;
  logic [CNT_W:0]   occupancy;
  logic [XLEN-1:0]  fifo_data_q [PREFETCH_DEPTH];
  logic             fifo_err_q  [PREFETCH_DEPTH];
  logic             rd_ptr_q;
  logic             wr_ptr_q;
  logic             gnt_ok;
  logic             drop_rsp;
  logic             fifo_push;
  logic             fifo_pop;

  // ------------------------------------------------------------------
  // request side
  // ------------------------------------------------------------------
  // fifo words plus granted requests must fit the buffer
  assign occupancy = {1'b0, out_cnt_q} + {1'b0, fifo_cnt_q};

  // an ungranted request stays up, even across a flush
  assign instr_req_o  = wait_q | (fetch_en_i & ~stream.branch & (occupancy < DEPTH_C));
  assign instr_addr_o = addr_q;
  assign gnt_ok       = instr_req_o & instr_gnt_i;

  assign out_cnt_d = out_cnt_q + CNT_W'(gnt_ok) - CNT_W'(instr_rvalid_i);

  // ------------------------------------------------------------------
  // response side
  // ------------------------------------------------------------------
  // responses of pre-flush requests never reach the fifo
  assign drop_rsp  = stream.branch | (disc_cnt_q != '0);
  assign fifo_push = instr_rvalid_i & ~drop_rsp;
  assign fifo_pop  = stream.valid & stream.ready & ~stream.branch;

  assign stream.valid  = (fifo_cnt_q != '0);
  assign stream.rdata  = fifo_data_q[rd_ptr_q];
  assign stream.failed = fifo_err_q[rd_ptr_q];

  assign busy_o = (out_cnt_q != '0) | (fifo_cnt_q != '0);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      addr_q     <= '0;
      wait_q     <= 1'b0;
      stale_q    <= 1'b0;
      out_cnt_q  <= '0;
      disc_cnt_q <= '0;
      fifo_cnt_q <= '0;
      rd_ptr_q   <= 1'b0;
      wr_ptr_q   <= 1'b0;
    end else begin
      wait_q    <= instr_req_o & ~instr_gnt_i;
      out_cnt_q <= out_cnt_d;
      if (stream.branch) begin
        // old request still waiting, target goes to pend_addr_q
        if (wait_q && !instr_gnt_i) begin
          stale_q <= 1'b1;
        end else begin
          addr_q  <= stream.branch_addr;
          stale_q <= 1'b0;
        end
        // everything in flight now belongs to the old stream
        disc_cnt_q <= out_cnt_d;
        fifo_cnt_q <= '0;
        rd_ptr_q   <= 1'b0;
        wr_ptr_q   <= 1'b0;
      end else begin
        if (gnt_ok && stale_q) begin
          addr_q  <= pend_addr_q;
          stale_q <= 1'b0;
        end else if (gnt_ok) begin
          addr_q <= addr_q + XLEN'(INSTR_BYTES);
        end
        disc_cnt_q <= disc_cnt_q - CNT_W'(instr_rvalid_i && (disc_cnt_q != '0))
                      + CNT_W'(gnt_ok && stale_q);
        fifo_cnt_q <= fifo_cnt_q + CNT_W'(fifo_push) - CNT_W'(fifo_pop);
        if (fifo_push) wr_ptr_q <= wr_ptr_q + 1'b1;
        if (fifo_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  // fifo storage and held redirect target
  always_ff @(posedge clk) begin
    if (fifo_push) begin
      fifo_data_q[wr_ptr_q] <= instr_rdata_i;
      fifo_err_q[wr_ptr_q]  <= instr_err_i;
    end
    if (stream.branch) pend_addr_q <= stream.branch_addr;
  end

endmodule

// ==== if_stage.sv ====
`timescale 1ns/1ps

module if_stage
  import fetch_defs_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  fetch_stream_if.fetch          stream,
  input  logic                   fetch_en_i,
  // configuration
  input  logic [XLEN-1:0]        boot_addr_i,
  input  logic [TRAP_BASE_W-1:0] m_trap_base_i,
  input  logic [TRAP_BASE_W-1:0] u_trap_base_i,
  input  logic [TRAP_BASE_W-1:0] mx_trap_base_i,
  input  logic [XLEN-1:0]        halt_addr_i,
  // pc selection from the controller
  input  trap_mux_e              trap_addr_mux_i,
  input  pc_mux_e                pc_mux_i,
  input  exc_pc_mux_e            exc_pc_mux_i,
  input  logic [VEC_ID_W-1:0]    exc_vec_id_i,
  input  logic                   pc_set_i,
  input  logic [XLEN-1:0]        pc_i,
  input  logic [XLEN-1:0]        jump_target_id_i,
  input  logic [XLEN-1:0]        jump_target_ex_i,
  input  logic [XLEN-1:0]        mepc_i,
  input  logic [XLEN-1:0]        depc_i,
  // pipeline control
  input  logic                   clear_instr_valid_i,
  input  logic                   halt_if_i,
  input  logic                   id_ready_i,
  // if/id register
  output logic                   instr_valid_id_o,
  output logic [XLEN-1:0]        instr_rdata_id_o,
  output logic                   is_fetch_failed_o,
  output logic [XLEN-1:0]        branch_target_o,
  output logic                   perf_imiss_o
);

  offset_state_e          state_q;
  offset_state_e          state_d;
  logic [TRAP_BASE_W-1:0] trap_base;
  logic [XLEN-1:0]        exc_pc;
  logic [XLEN-1:0]        next_pc;
  logic                   instr_err_q;

  // ------------------------------------------------------------------
  // exception and next pc selection
  // ------------------------------------------------------------------
  always_comb begin
    case (trap_addr_mux_i)
      TRAP_USER:     trap_base = u_trap_base_i;
      TRAP_MACHINEX: trap_base = mx_trap_base_i;
      // machine mode and unused codes
      default:       trap_base = m_trap_base_i;
    endcase
    case (exc_pc_mux_i)
      // interrupts are vectored, one word per cause
      EXC_PC_IRQ: exc_pc = {trap_base, 1'b0, exc_vec_id_i, {IRQ_PAD_W{1'b0}}};
      EXC_PC_DBD: exc_pc = halt_addr_i;
      default:    exc_pc = {trap_base, {EXC_OFF_W{1'b0}}};
    endcase
  end

  always_comb begin
    case (pc_mux_i)
      PC_JUMP:      next_pc = jump_target_id_i;
      PC_BRANCH:    next_pc = jump_target_ex_i;
      PC_EXCEPTION: next_pc = exc_pc;
      PC_MRET:      next_pc = mepc_i;
      PC_DRET:      next_pc = depc_i;
      // refetch after the fence
      PC_FENCEI:    next_pc = pc_i + XLEN'(INSTR_BYTES);
      default:      next_pc = boot_addr_i;
    endcase
  end

  assign branch_target_o    = {next_pc[XLEN-1:1], 1'b0};
  // first branch out of IDLE always goes to the boot address
  assign stream.branch_addr = pc_set_i ? branch_target_o : boot_addr_i;

  // ------------------------------------------------------------------
  // offset fsm
  // ------------------------------------------------------------------
  always_comb begin
    state_d       = state_q;
    stream.branch = 1'b0;
    stream.ready  = 1'b0;
    case (state_q)
      IDLE: begin
        if (fetch_en_i) begin
          stream.branch = 1'b1;
          state_d       = WAIT;
        end
      end
      WAIT: begin
        // take the head word only if decode can accept it
        stream.ready = stream.valid & fetch_en_i & id_ready_i & ~halt_if_i;
      end
      default: state_d = IDLE;
    endcase
    // redirect kills the word on the stream
    if (pc_set_i) begin
      stream.ready  = 1'b0;
      stream.branch = 1'b1;
      state_d       = WAIT;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign perf_imiss_o = ~stream.valid | stream.branch;

  // ------------------------------------------------------------------
  // if/id pipeline register, holds while decode stalls
  // ------------------------------------------------------------------
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_id_o  <= 1'b0;
      is_fetch_failed_o <= 1'b0;
      instr_err_q       <= 1'b0;
    end else if (stream.ready) begin
      instr_valid_id_o  <= 1'b1;
      instr_err_q       <= stream.failed;
      is_fetch_failed_o <= 1'b0;
    end else if (clear_instr_valid_i) begin
      // error of the word just killed becomes visible
      instr_valid_id_o  <= 1'b0;
      is_fetch_failed_o <= instr_err_q;
    end
  end

  always_ff @(posedge clk) begin
    if (stream.ready) instr_rdata_id_o <= stream.rdata;
  end

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top
  import fetch_defs_pkg::*, fetch_csr_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  // apb configuration port
  input  apb_addr_t             paddr_i,
  input  logic [APB_DATA_W-1:0] pwdata_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  output logic [APB_DATA_W-1:0] prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o,
  // instruction memory
  output logic                  instr_req_o,
  output logic [XLEN-1:0]       instr_addr_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  logic [XLEN-1:0]       instr_rdata_i,
  input  logic                  instr_err_i,
  // core control
  input  trap_mux_e             trap_addr_mux_i,
  input  pc_mux_e               pc_mux_i,
  input  exc_pc_mux_e           exc_pc_mux_i,
  input  logic [VEC_ID_W-1:0]   exc_vec_id_i,
  input  logic                  pc_set_i,
  input  logic [XLEN-1:0]       pc_i,
  input  logic [XLEN-1:0]       jump_target_id_i,
  input  logic [XLEN-1:0]       jump_target_ex_i,
  input  logic [XLEN-1:0]       mepc_i,
  input  logic [XLEN-1:0]       depc_i,
  input  logic                  clear_instr_valid_i,
  input  logic                  halt_if_i,
  input  logic                  id_ready_i,
  // towards decode
  output logic                  instr_valid_id_o,
  output logic [XLEN-1:0]       instr_rdata_id_o,
  output logic                  is_fetch_failed_o,
  output logic [XLEN-1:0]       branch_target_o,
  output logic                  perf_imiss_o,
  output logic                  if_busy_o
);

  logic [XLEN-1:0]        boot_addr;
  logic [TRAP_BASE_W-1:0] m_trap_base;
  logic [TRAP_BASE_W-1:0] u_trap_base;
  logic [TRAP_BASE_W-1:0] mx_trap_base;
  logic [XLEN-1:0]        halt_addr;
  logic                   fetch_en;

  fetch_stream_if stream_if ();

  // apb ports connect by name
  fetch_csr_apb csr_i (
    .*,
    .boot_addr_o    (boot_addr),
    .m_trap_base_o  (m_trap_base),
    .u_trap_base_o  (u_trap_base),
    .mx_trap_base_o (mx_trap_base),
    .halt_addr_o    (halt_addr),
    .fetch_en_o     (fetch_en)
  );

  if_stage if_stage_i (
    .*,
    .stream         (stream_if),
    .fetch_en_i     (fetch_en),
    .boot_addr_i    (boot_addr),
    .m_trap_base_i  (m_trap_base),
    .u_trap_base_i  (u_trap_base),
    .mx_trap_base_i (mx_trap_base),
    .halt_addr_i    (halt_addr)
  );

  prefetch_buffer prefetch_buffer_i (
    .*,
    .fetch_en_i (fetch_en),
    .stream     (stream_if),
    .busy_o     (if_busy_o)
  );

endmodule

// ==== fetch_properties.sv ====
`timescale 1ns/1ps

module fetch_properties (
  input logic        clk,
  input logic        rst_n,
  input logic        instr_req_o,
  input logic [31:0] instr_addr_o,
  input logic        instr_gnt_i,
  input logic        id_ready_i,
  input logic        clear_instr_valid_i,
  input logic        instr_valid_id_o,
  input logic [31:0] instr_rdata_id_o,
  input logic        is_fetch_failed_o,
  input logic        pslverr_o,
  input logic        if_busy_o
);

  // ------------------------------------------------------------------
  // memory port handshake
  // ------------------------------------------------------------------
  gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    instr_gnt_i |-> instr_req_o)
    else $error("grant seen without a pending request");

  // a waiting request keeps its address until granted
  addr_held: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_o && !instr_gnt_i) |=> (instr_req_o && $stable(instr_addr_o)))
    else $error("request dropped or address moved before grant");

  // ------------------------------------------------------------------
  // if/id register under decode stall
  // ------------------------------------------------------------------
  ifid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (!id_ready_i && !clear_instr_valid_i) |=>
      ($stable(instr_valid_id_o) && $stable(instr_rdata_id_o)))
    else $error("if/id register changed while decode stalled");

  // control outputs quiet on the first clock out of reset
  reset_quiet: assert property (@(posedge clk)
    $rose(rst_n) |-> !(instr_req_o || instr_valid_id_o || is_fetch_failed_o
                       || pslverr_o || if_busy_o))
    else $error("control output high right after reset");

endmodule

bind fetch_top fetch_properties props_i (.*);

// ==== tb_fetch_top.sv ====
`timescale 1ns/1ps

module tb_fetch_top
  import fetch_defs_pkg::*, fetch_csr_pkg::*;
;

  // data word is address xor key, so the address is recoverable
  localparam logic [31:0] KEY       = 32'hA5C3_0F96;
  localparam logic [31:0] ERR_LO    = 32'h0000_3000;
  localparam logic [31:0] ERR_HI    = 32'h0000_30FF;
  // apb ~60, redirects ~200, random span 300, error test ~60 cycles
  localparam int          MAX_CYCLE = 4000;

  logic clk;
  logic rst_n;
  apb_addr_t paddr_i;
  logic [31:0] pwdata_i;
  logic psel_i;
  logic penable_i;
  logic pwrite_i;
  logic [31:0] prdata_o;
  logic pready_o;
  logic pslverr_o;
  logic instr_req_o;
  logic [31:0] instr_addr_o;
  logic instr_gnt_i;
  logic instr_rvalid_i;
  logic [31:0] instr_rdata_i;
  logic instr_err_i;
  trap_mux_e trap_addr_mux_i;
  pc_mux_e pc_mux_i;
  exc_pc_mux_e exc_pc_mux_i;
  logic [4:0] exc_vec_id_i;
  logic pc_set_i;
  logic [31:0] pc_i;
  logic [31:0] jump_target_id_i;
  logic [31:0] jump_target_ex_i;
  logic [31:0] mepc_i;
  logic [31:0] depc_i;
  logic clear_instr_valid_i;
  logic halt_if_i;
  logic id_ready_i;
  logic instr_valid_id_o;
  logic [31:0] instr_rdata_id_o;
  logic is_fetch_failed_o;
  logic [31:0] branch_target_o;
  logic perf_imiss_o;
  logic if_busy_o;

  int          errors;
  int          tests_run;
  int          tests_bad;
  int          words;
  int          cycles;
  int          gnt_wait;
  logic [31:0] exp_pc;
  logic [31:0] pend_exp;
  bit          chk_pending;
  logic [31:0] rsp_q[$];

  fetch_top fetch_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
    errors++;
  endtask

  task automatic close_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errors - err_before);
    end
  endtask

  task automatic apb_write(input apb_addr_t addr, input logic [31:0] data,
                           input logic exp_err);
    tick();
    psel_i   = 1'b1;
    pwrite_i = 1'b1;
    paddr_i  = addr;
    pwdata_i = data;
    tick();
    penable_i = 1'b1;
    #1;
    assert (pslverr_o == exp_err) else report_mismatch("pslverr_o", 32'(exp_err), 32'(pslverr_o));
    assert (pready_o == 1'b1) else report_mismatch("pready_o", 32'h1, 32'(pready_o));
    tick();
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, input logic [31:0] exp);
    tick();
    psel_i   = 1'b1;
    pwrite_i = 1'b0;
    paddr_i  = addr;
    tick();
    penable_i = 1'b1;
    #1;
    assert (prdata_o == exp) else report_mismatch("prdata_o", exp, prdata_o);
    assert (pready_o == 1'b1) else report_mismatch("pready_o", 32'h1, 32'(pready_o));
    tick();
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic wait_words(input int n);
    int target;
    target = words + n;
    while (words < target) tick();
  endtask

  // one redirect cycle, then a few words from the new stream
  task automatic redirect(input pc_mux_e sel, input exc_pc_mux_e esel,
                          input trap_mux_e tsel, input logic [4:0] vec,
                          input logic [31:0] exp);
    tick();
    pc_set_i        = 1'b1;
    pc_mux_i        = sel;
    exc_pc_mux_i    = esel;
    trap_addr_mux_i = tsel;
    exc_vec_id_i    = vec;
    #1;
    assert (branch_target_o == exp) else report_mismatch("branch_target_o", exp, branch_target_o);
    exp_pc = exp;
    tick();
    pc_set_i = 1'b0;
    wait_words(3);
  endtask

  // ------------------------------------------------------------------
  // memory model, grant at 2 ns, handshake sampled at 3 ns
  // ------------------------------------------------------------------
  initial begin
    forever begin
      @(posedge clk);
      #1;
      instr_rvalid_i = 1'b0;
      if (rsp_q.size() > 0) begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = rsp_q[0] ^ KEY;
        instr_err_i    = (rsp_q[0] >= ERR_LO) && (rsp_q[0] <= ERR_HI);
        rsp_q.delete(0);
      end
      #1;
      instr_gnt_i = 1'b0;
      if (instr_req_o) begin
        if (gnt_wait == 0) begin
          instr_gnt_i = 1'b1;
          gnt_wait    = $urandom % 3;
        end else begin
          gnt_wait--;
        end
      end
      #1;
      // words granted earlier and not yet returned keep the buffer busy
      assert (rsp_q.size() == 0 || if_busy_o)
        else report_mismatch("if_busy_o", 32'h1, 32'(if_busy_o));
      if (instr_req_o && instr_gnt_i) rsp_q.push_back(instr_addr_o);
      assert (rsp_q.size() <= 2) else begin
        $display("more than two requests outstanding at t=%0t", $time);
        errors++;
      end
    end
  end

  // ------------------------------------------------------------------
  // delivered word monitor, sampled at 3 ns
  // ------------------------------------------------------------------
  initial begin
    forever begin
      @(posedge clk);
      #3;
      if (chk_pending) begin
        assert (instr_rdata_id_o == (pend_exp ^ KEY))
          else report_mismatch("instr_rdata_id_o", pend_exp ^ KEY, instr_rdata_id_o);
        words++;
      end
      // word taken into if/id on the coming edge
      chk_pending = rst_n && !perf_imiss_o && id_ready_i && !halt_if_i && !pc_set_i;
      if (chk_pending) begin
        pend_exp = exp_pc;
        exp_pc   = exp_pc + 32'd4;
      end
    end
  end

  // watchdog
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLE) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, run stopped", cycles);
    $display("Some tests failed");
    $finish;
  end

  // ------------------------------------------------------------------
  // directed and random tests
  // ------------------------------------------------------------------
  initial begin
    int e0;
    void'($urandom(40));
    errors = 0;
    tests_run = 0;
    tests_bad = 0;
    words = 0;
    gnt_wait = 0;
    chk_pending = 1'b0;
    exp_pc = 32'h0;
    rst_n = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    instr_gnt_i = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i = '0;
    instr_err_i = 1'b0;
    trap_addr_mux_i = TRAP_MACHINE;
    pc_mux_i = PC_BOOT;
    exc_pc_mux_i = EXC_PC_EXCEPTION;
    exc_vec_id_i = '0;
    pc_set_i = 1'b0;
    pc_i = 32'h0000_0F00;
    jump_target_id_i = 32'h0000_0800;
    jump_target_ex_i = 32'h0000_0A00;
    mepc_i = 32'h0000_0C00;
    depc_i = 32'h0000_0E01;
    clear_instr_valid_i = 1'b0;
    halt_if_i = 1'b0;
    id_ready_i = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // register map
    e0 = errors;
    apb_write(CSR_BOOT, 32'h0000_0101, 1'b0);
    apb_write(CSR_MTVEC, 32'h0012_3400, 1'b0);
    apb_write(CSR_UTVEC, 32'h0056_7800, 1'b0);
    apb_write(CSR_MTVECX, 32'h009A_BC00, 1'b0);
    apb_write(CSR_HALT, 32'h0000_0600, 1'b0);
    apb_write(8'h18, 32'hFFFF_FFFF, 1'b1);
    apb_read(CSR_BOOT, 32'h0000_0100);
    apb_read(CSR_MTVEC, 32'h0012_3400);
    apb_read(CSR_UTVEC, 32'h0056_7800);
    apb_read(CSR_MTVECX, 32'h009A_BC00);
    apb_read(CSR_HALT, 32'h0000_0600);
    apb_read(CSR_CTRL, 32'h0);
    close_test("apb registers", e0);

    // sequential fetch from the boot address
    e0 = errors;
    exp_pc = 32'h0000_0100;
    apb_write(CSR_CTRL, 32'h1, 1'b0);
    do begin
      tick();
      #2;
    end while (!instr_req_o);
    assert (instr_addr_o == 32'h0000_0100)
      else report_mismatch("instr_addr_o", 32'h0000_0100, instr_addr_o);
    wait_words(6);
    apb_read(CSR_CTRL, 32'h1);
    close_test("boot fetch", e0);

    // every pc source, trap bases and vectored interrupt
    e0 = errors;
    redirect(PC_JUMP, EXC_PC_EXCEPTION, TRAP_MACHINE, 5'd0, 32'h0000_0800);
    redirect(PC_BRANCH, EXC_PC_EXCEPTION, TRAP_MACHINE, 5'd0, 32'h0000_0A00);
    redirect(PC_MRET, EXC_PC_EXCEPTION, TRAP_MACHINE, 5'd0, 32'h0000_0C00);
    redirect(PC_DRET, EXC_PC_EXCEPTION, TRAP_MACHINE, 5'd0, 32'h0000_0E00);
    redirect(PC_FENCEI, EXC_PC_EXCEPTION, TRAP_MACHINE, 5'd0, 32'h0000_0F04);
    redirect(PC_BOOT, EXC_PC_EXCEPTION, TRAP_MACHINE, 5'd0, 32'h0000_0100);
    redirect(PC_EXCEPTION, EXC_PC_EXCEPTION, TRAP_MACHINE, 5'd0, 32'h0012_3400);
    redirect(PC_EXCEPTION, EXC_PC_EXCEPTION, TRAP_USER, 5'd0, 32'h0056_7800);
    // base << 8, then cause index in word steps
    redirect(PC_EXCEPTION, EXC_PC_IRQ, TRAP_MACHINEX, 5'd5,
             (32'h009A_BC << 8) | (32'd5 << 2));
    redirect(PC_EXCEPTION, EXC_PC_DBD, TRAP_MACHINE, 5'd0, 32'h0000_0600);
    close_test("redirects", e0);

    // random decode stalls and halts
    e0 = errors;
    repeat (300) begin
      tick();
      id_ready_i = ($urandom % 4) != 0;
      halt_if_i  = ($urandom % 6) == 0;
    end
    tick();
    id_ready_i = 1'b1;
    halt_if_i  = 1'b0;
    wait_words(4);
    close_test("back-pressure", e0);

    // error range then a good word
    e0 = errors;
    jump_target_id_i = ERR_LO;
    redirect(PC_JUMP, EXC_PC_EXCEPTION, TRAP_MACHINE, 5'd0, ERR_LO);
    id_ready_i = 1'b0;
    tick();
    clear_instr_valid_i = 1'b1;
    tick();
    clear_instr_valid_i = 1'b0;
    #2;
    assert (is_fetch_failed_o == 1'b1) else report_mismatch("is_fetch_failed_o", 32'h1, 32'h0);
    tick();
    id_ready_i = 1'b1;
    jump_target_ex_i = 32'h0000_0400;
    redirect(PC_BRANCH, EXC_PC_EXCEPTION, TRAP_MACHINE, 5'd0, 32'h0000_0400);
    assert (is_fetch_failed_o == 1'b0) else report_mismatch("is_fetch_failed_o", 32'h0, 32'h1);
    close_test("fetch error", e0);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
fetch_defs_pkg.sv
fetch_csr_pkg.sv
fetch_stream_if.sv
fetch_csr_apb.sv
prefetch_buffer.sv
if_stage.sv
fetch_top.sv
fetch_properties.sv
tb_fetch_top.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tb_fetch_top -f filelist.f -o sim_fetch \
  && ./obj_dir/sim_fetch > sim.log 2>&1 || echo "build or run error"
cat sim.log 2>/dev/null
grep -qx "All tests passed" sim.log || exit 1
